// ==== include/pl_macros.svh ====
// Address map and fixed constants shared by the AXI slave, the register banks and the testbench
`ifndef PL_MACROS_SVH
`define PL_MACROS_SVH

// Byte address width of the host window
`define PL_ADDR_WIDTH 10

// Selects the DSP bank when set and the control bank when clear
`define PL_BANK_BIT 9

// ------------------------------
// Control bank
// ------------------------------
`define PL_REG_ID      10'h000
`define PL_REG_SCRATCH 10'h004
`define PL_REG_SOFTRST 10'h008
`define PL_REG_COUNT   10'h00C

// ------------------------------
// DSP bank
// ------------------------------
`define PL_REG_MODE   10'h200
`define PL_REG_GAIN   10'h204
`define PL_REG_OFFSET 10'h208

`define PL_ID_VALUE 32'h504C0001

`endif

// ==== source/pl_pkg.sv ====
// Shared types for the sample pipeline, the AXI slave and the testbench model
package pl_pkg;

	// ------------------------------
	// AXI response codes
	// ------------------------------
	typedef enum logic [1:0] {
		OKAY   = 2'd0,
		SLVERR = 2'd2 // Unmapped offset or write to a read-only register
	} axi_resp_e;

	// ------------------------------
	// Sample word
	// ------------------------------

	// The same 32 bits are read either as one real sample or as an IQ pair
	typedef union packed {
		logic [31:0] raw; // Real mode sample
		struct packed {
			logic signed [15:0] i; // In-phase half sits in the upper bits
			logic signed [15:0] q;
		} iq;
	} sample_word_u;

endpackage

// ==== source/axil_slave.sv ====
// AXI4-Lite slave that sequences host accesses into local-bus cycles for the control and DSP banks
`timescale 1ns/1ps
`include "pl_macros.svh"

module axil_slave
	import pl_pkg::*;
(
	input  logic                      cfgclk,
	input  logic                      rst_n,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`PL_ADDR_WIDTH-1:0] awaddr,
	input  logic                      wvalid,
	output logic                      wready,
	input  logic [31:0]               wdata,
	output logic                      bvalid,
	input  logic                      bready,
	output axi_resp_e                 bresp,
	input  logic                      arvalid,
	output logic                      arready,
	input  logic [`PL_ADDR_WIDTH-1:0] araddr,
	output logic                      rvalid,
	input  logic                      rready,
	output logic [31:0]               rdata,
	output axi_resp_e                 rresp,
	output logic                      lb_wr,
	output logic                      lb_rd,
	output logic [`PL_ADDR_WIDTH-1:0] lb_addr,
	output logic [31:0]               lb_wdata,
	output logic                      ctrl_sel,
	output logic                      dsp_sel,
	input  logic [31:0]               ctrl_rdata,
	input  logic                      ctrl_err,
	input  logic [31:0]               dsp_rdata,
	input  logic                      dsp_err
);
	localparam logic [2:0] S_IDLE    = 3'd0;
	localparam logic [2:0] S_WR      = 3'd1; // Write handshake and local-bus write
	localparam logic [2:0] S_RD      = 3'd2; // Read handshake and local-bus read
	localparam logic [2:0] S_RD_WAIT = 3'd3; // Bank read data is registered
	localparam logic [2:0] S_BRESP   = 3'd4;
	localparam logic [2:0] S_RRESP   = 3'd5;

	logic [2:0] state;
	logic       rd_bank; // Bank bit of the read in flight
	logic       rd_err;

	assign awready = (state == S_WR);
	assign wready  = (state == S_WR);
	assign arready = (state == S_RD);
	assign bvalid  = (state == S_BRESP);
	assign rvalid  = (state == S_RRESP);

	// Host address is still held during the handshake cycle
	assign lb_wr    = (state == S_WR);
	assign lb_rd    = (state == S_RD);
	assign lb_addr  = lb_wr ? awaddr : araddr;
	assign lb_wdata = wdata;
	assign ctrl_sel = (lb_wr || lb_rd) && !lb_addr[`PL_BANK_BIT];
	assign dsp_sel  = (lb_wr || lb_rd) && lb_addr[`PL_BANK_BIT];
	assign rd_err   = rd_bank ? dsp_err : ctrl_err;

	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			state <= S_IDLE;
		end else begin
			case (state)
				S_IDLE: begin
					if (arvalid) begin // Reads win a tie with writes
						state <= S_RD;
					end else if (awvalid && wvalid) begin
						state <= S_WR;
					end
				end
				S_WR:      state <= S_BRESP;
				S_RD:      state <= S_RD_WAIT;
				S_RD_WAIT: state <= S_RRESP;
				S_BRESP:   state <= bready ? S_IDLE : S_BRESP;
				S_RRESP:   state <= rready ? S_IDLE : S_RRESP;
				default:   state <= S_IDLE;
			endcase
		end
	end

	// Response payload only changes when a new access is being completed
	always_ff @(posedge cfgclk) begin
		if (state == S_WR) begin
			bresp <= (dsp_sel ? dsp_err : ctrl_err) ? SLVERR : OKAY;
		end
		if (state == S_RD) begin
			rd_bank <= lb_addr[`PL_BANK_BIT];
		end
		if (state == S_RD_WAIT) begin
			rresp <= rd_err ? SLVERR : OKAY;
			rdata <= rd_err ? 32'd0 : (rd_bank ? dsp_rdata : ctrl_rdata);
		end
	end

endmodule

// ==== source/ctrl_regs.sv ====
// Control register bank with identity, scratch, DSP soft reset and the processed-sample counter
`timescale 1ns/1ps
`include "pl_macros.svh"

module ctrl_regs (
	input  logic                      cfgclk,
	input  logic                      rst_n,
	input  logic                      sel,
	input  logic                      lb_wr,
	input  logic                      lb_rd,
	input  logic [`PL_ADDR_WIDTH-1:0] lb_addr,
	input  logic [31:0]               lb_wdata,
	output logic [31:0]               lb_rdata,
	output logic                      lb_err,
	input  logic                      sample_done,
	output logic                      dsp_rst_n
);
	logic [31:0] scratch;
	logic        soft_rst;
	logic [31:0] count; // Wraps and clears only on rst_n
	logic        wr_err;
	logic        rd_err_q;
	logic        rd_hit;
	logic [31:0] rd_word;

	// Only scratch and soft reset accept writes
	assign wr_err = (lb_addr != `PL_REG_SCRATCH) && (lb_addr != `PL_REG_SOFTRST);

	always_comb begin
		rd_hit = 1'b1;
		case (lb_addr)
			`PL_REG_ID:      rd_word = `PL_ID_VALUE;
			`PL_REG_SCRATCH: rd_word = scratch;
			`PL_REG_SOFTRST: rd_word = {31'd0, soft_rst};
			`PL_REG_COUNT:   rd_word = count;
			default: begin
				rd_word = 32'd0;
				rd_hit  = 1'b0;
			end
		endcase
	end

	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			scratch  <= 32'd0;
			soft_rst <= 1'b0;
			count    <= 32'd0;
			rd_err_q <= 1'b0;
		end else begin
			if (sel && lb_wr && lb_addr == `PL_REG_SCRATCH) scratch <= lb_wdata;
			if (sel && lb_wr && lb_addr == `PL_REG_SOFTRST) soft_rst <= lb_wdata[0];
			if (sample_done) count <= count + 32'd1;
			rd_err_q <= sel && lb_rd && !rd_hit;
		end
	end

	always_ff @(posedge cfgclk) begin
		if (sel && lb_rd) lb_rdata <= rd_word; // Read data lags lb_rd by one cycle
	end

	assign lb_err    = (sel && lb_wr) ? wr_err : rd_err_q;
	assign dsp_rst_n = rst_n && !soft_rst;

endmodule

// ==== source/dsp_regs.sv ====
// DSP register bank holding the processing mode, the IQ gain and the real-mode offset
`timescale 1ns/1ps
`include "pl_macros.svh"

module dsp_regs (
	input  logic                      cfgclk,
	input  logic                      rst_n,
	input  logic                      sel,
	input  logic                      lb_wr,
	input  logic                      lb_rd,
	input  logic [`PL_ADDR_WIDTH-1:0] lb_addr,
	input  logic [31:0]               lb_wdata,
	output logic [31:0]               lb_rdata,
	output logic                      lb_err,
	output logic                      mode,   // 1 selects IQ processing
	output logic signed [15:0]        gain,   // Signed Q8.8
	output logic [31:0]               offset
);
	logic rd_err_q;
	logic hit; // Offset is one of the three DSP registers

	assign hit = (lb_addr == `PL_REG_MODE) || (lb_addr == `PL_REG_GAIN) ||
		(lb_addr == `PL_REG_OFFSET);

	always_ff @(posedge cfgclk) begin
		if (!rst_n) begin
			mode     <= 1'b0;
			gain     <= 16'sh0100; // Unity gain
			offset   <= 32'd0;
			rd_err_q <= 1'b0;
		end else begin
			if (sel && lb_wr && lb_addr == `PL_REG_MODE) mode <= lb_wdata[0];
			if (sel && lb_wr && lb_addr == `PL_REG_GAIN) gain <= lb_wdata[15:0];
			if (sel && lb_wr && lb_addr == `PL_REG_OFFSET) offset <= lb_wdata;
			rd_err_q <= sel && lb_rd && !hit;
		end
	end

	always_ff @(posedge cfgclk) begin
		if (sel && lb_rd) begin
			case (lb_addr)
				`PL_REG_MODE:   lb_rdata <= {31'd0, mode};
				`PL_REG_GAIN:   lb_rdata <= {16'd0, gain}; // Zero-extended on read
				`PL_REG_OFFSET: lb_rdata <= offset;
				default:        lb_rdata <= 32'd0;
			endcase
		end
	end

	assign lb_err = (sel && lb_wr) ? !hit : rd_err_q;

endmodule

// ==== source/sample_proc.sv ====
// Two-stage valid/ready sample pipeline applying the real-mode offset or the saturating IQ gain
`timescale 1ns/1ps

module sample_proc
	import pl_pkg::*;
(
	input  logic               cfgclk,
	input  logic               dsp_rst_n,
	input  logic               mode,
	input  logic signed [15:0] gain,
	input  logic [31:0]        offset,
	input  logic               s_tvalid,
	output logic               s_tready,
	input  logic [31:0]        s_tdata,
	output logic               m_tvalid,
	input  logic               m_tready,
	output logic [31:0]        m_tdata,
	output logic               sample_done
);
	// Multiply by Q8.8, floor shift by 8, clamp to 16 bits
	function automatic logic signed [15:0] scale_sat(input logic signed [15:0] x,
		input logic signed [15:0] g);
		logic signed [31:0] prod;
		logic signed [23:0] shifted;
		prod    = x * g;
		shifted = prod[31:8]; // Dropping the low byte floors toward minus infinity
		if (shifted > 24'sd32767) return 16'sh7fff;
		else if (shifted < -24'sd32768) return 16'sh8000;
		else return shifted[15:0];
	endfunction

	// ------------------------------
	// Stage one holds the word and its configuration
	// ------------------------------
	logic               s1_valid;
	sample_word_u       s1_word;
	logic               s1_mode;
	logic signed [15:0] s1_gain;
	logic [31:0]        s1_offset;
	logic               m_free; // Output stage is empty or drains this cycle
	sample_word_u       result;

	assign m_free      = !m_tvalid || m_tready;
	assign s_tready    = !s1_valid || m_free;
	assign sample_done = m_tvalid && m_tready;

	always_comb begin
		if (s1_mode) begin
			result.iq.i = scale_sat(s1_word.iq.i, s1_gain);
			result.iq.q = scale_sat(s1_word.iq.q, s1_gain);
		end else begin
			result.raw = s1_word.raw + s1_offset; // Wraps on overflow
		end
	end

	always_ff @(posedge cfgclk) begin
		if (!dsp_rst_n) begin
			s1_valid <= 1'b0;
			m_tvalid <= 1'b0;
		end else begin
			if (s_tready) s1_valid <= s_tvalid;
			if (m_free) m_tvalid <= s1_valid;
		end
	end

	// Configuration is sampled together with the beat it applies to
	always_ff @(posedge cfgclk) begin
		if (s_tvalid && s_tready) begin
			s1_word.raw <= s_tdata;
			s1_mode     <= mode;
			s1_gain     <= gain;
			s1_offset   <= offset;
		end
		if (s1_valid && m_free) m_tdata <= result.raw;
	end

endmodule

// ==== source/pl_top.sv ====
// Programmable-logic top joining the AXI4-Lite slave, both register banks and the sample pipeline
`timescale 1ns/1ps
`include "pl_macros.svh"

module pl_top
	import pl_pkg::*;
(
	input  logic                      cfgclk,
	input  logic                      rst_n,
	input  logic                      awvalid,
	output logic                      awready,
	input  logic [`PL_ADDR_WIDTH-1:0] awaddr,
	input  logic                      wvalid,
	output logic                      wready,
	input  logic [31:0]               wdata,
	output logic                      bvalid,
	input  logic                      bready,
	output axi_resp_e                 bresp,
	input  logic                      arvalid,
	output logic                      arready,
	input  logic [`PL_ADDR_WIDTH-1:0] araddr,
	output logic                      rvalid,
	input  logic                      rready,
	output logic [31:0]               rdata,
	output axi_resp_e                 rresp,
	input  logic                      s_tvalid,
	output logic                      s_tready,
	input  logic [31:0]               s_tdata,
	output logic                      m_tvalid,
	input  logic                      m_tready,
	output logic [31:0]               m_tdata
);
	// ------------------------------
	// Local bus and side-band wires
	// ------------------------------
	logic                      lb_wr;
	logic                      lb_rd;
	logic [`PL_ADDR_WIDTH-1:0] lb_addr;
	logic [31:0]               lb_wdata;
	logic                      ctrl_sel;
	logic                      dsp_sel;
	logic [31:0]               ctrl_rdata;
	logic                      ctrl_err;
	logic [31:0]               dsp_rdata;
	logic                      dsp_err;
	logic                      dsp_rst_n; // Also held low by the soft-reset bit
	logic                      sample_done;
	logic                      mode;
	logic signed [15:0]        gain;
	logic [31:0]               offset;

	axil_slave axil_slave_i (
		.cfgclk(cfgclk), .rst_n(rst_n),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
		.lb_wr(lb_wr), .lb_rd(lb_rd), .lb_addr(lb_addr), .lb_wdata(lb_wdata),
		.ctrl_sel(ctrl_sel), .dsp_sel(dsp_sel),
		.ctrl_rdata(ctrl_rdata), .ctrl_err(ctrl_err),
		.dsp_rdata(dsp_rdata), .dsp_err(dsp_err)
	);

	ctrl_regs ctrl_regs_i (
		.cfgclk(cfgclk), .rst_n(rst_n), .sel(ctrl_sel),
		.lb_wr(lb_wr), .lb_rd(lb_rd), .lb_addr(lb_addr), .lb_wdata(lb_wdata),
		.lb_rdata(ctrl_rdata), .lb_err(ctrl_err),
		.sample_done(sample_done), .dsp_rst_n(dsp_rst_n)
	);

	dsp_regs dsp_regs_i (
		.cfgclk(cfgclk), .rst_n(rst_n), .sel(dsp_sel),
		.lb_wr(lb_wr), .lb_rd(lb_rd), .lb_addr(lb_addr), .lb_wdata(lb_wdata),
		.lb_rdata(dsp_rdata), .lb_err(dsp_err),
		.mode(mode), .gain(gain), .offset(offset)
	);

	sample_proc sample_proc_i (
		.cfgclk(cfgclk), .dsp_rst_n(dsp_rst_n),
		.mode(mode), .gain(gain), .offset(offset),
		.s_tvalid(s_tvalid), .s_tready(s_tready), .s_tdata(s_tdata),
		.m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata),
		.sample_done(sample_done)
	);

endmodule

// ==== dv/pl_sva.sv ====
// Handshake and reset assertions for pl_top, attached to every pl_top instance by bind
`timescale 1ns/1ps

module pl_sva
	import pl_pkg::*;
(
	input logic        cfgclk,
	input logic        rst_n,
	input logic        dsp_rst_n,
	input logic        bvalid,
	input logic        bready,
	input axi_resp_e   bresp,
	input logic        rvalid,
	input logic        rready,
	input logic [31:0] rdata,
	input axi_resp_e   rresp,
	input logic        m_tvalid,
	input logic        m_tready,
	input logic [31:0] m_tdata
);
	// ------------------------------
	// Outputs hold until taken
	// ------------------------------
	assert property (@(posedge cfgclk) disable iff (!rst_n)
		bvalid && !bready |=> bvalid && $stable(bresp))
		else $error("bvalid dropped or bresp changed before bready");

	assert property (@(posedge cfgclk) disable iff (!rst_n)
		rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rresp))
		else $error("rvalid dropped or read payload changed before rready");

	// Soft reset may flush a waiting beat
	assert property (@(posedge cfgclk) disable iff (!dsp_rst_n)
		m_tvalid && !m_tready |=> m_tvalid && $stable(m_tdata))
		else $error("m_tvalid dropped or m_tdata changed before m_tready");

	assert property (@(posedge cfgclk) !rst_n |=> !bvalid && !rvalid && !m_tvalid)
		else $error("A valid output was high in the cycle after reset");

endmodule

bind pl_top pl_sva pl_sva_i (
	.cfgclk(cfgclk), .rst_n(rst_n), .dsp_rst_n(dsp_rst_n),
	.bvalid(bvalid), .bready(bready), .bresp(bresp),
	.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp),
	.m_tvalid(m_tvalid), .m_tready(m_tready), .m_tdata(m_tdata)
);

// ==== dv/pl_tb.sv ====
// Testbench that drives pl_top through the register and stream tests against a model and reports the result
`timescale 1ns/1ps
`include "pl_macros.svh"

module pl_tb
	import pl_pkg::*;
();
	localparam int MAX_CYCLES = 10000; // 6 tests of up to 300 beats at 4 cycles each, with margin

	logic cfgclk;
	logic rst_n;
	logic awvalid, awready, wvalid, wready, bvalid, bready;
	logic arvalid, arready, rvalid, rready;
	logic s_tvalid, s_tready, m_tvalid, m_tready;
	logic [`PL_ADDR_WIDTH-1:0] awaddr, araddr;
	logic [31:0] wdata, rdata, s_tdata, m_tdata;
	axi_resp_e   bresp, rresp;

	// Register and stream model
	logic [31:0]        scratch_m, offset_m, count_m;
	logic               softrst_m, mode_m;
	logic signed [15:0] gain_m;
	logic [31:0]        exp_q[$]; // Expected output words in order
	int errors = 0;
	int tests_run = 0;
	int tests_failed = 0;
	int cycles = 0;
	int e0;

	pl_top dut_i (.*);

	initial cfgclk = 1'b0;
	always #50 cfgclk = ~cfgclk;

	always @(posedge cfgclk) begin
		cycles++;
		if (cycles >= MAX_CYCLES) begin
			$display("Run timed out after %0d cycles waiting on the DUT", cycles);
			$display("FAIL: see errors above");
			$finish;
		end
	end

	task automatic next_cycle();
		@(posedge cfgclk);
		#1; // Inputs change just after the edge
	endtask

	// ------------------------------
	// Reference model
	// ------------------------------
	function automatic axi_resp_e model_write(input logic [9:0] addr, input logic [31:0] data);
		case (addr)
			`PL_REG_SCRATCH: scratch_m = data;
			`PL_REG_SOFTRST: softrst_m = data[0];
			`PL_REG_MODE:    mode_m = data[0];
			`PL_REG_GAIN:    gain_m = data[15:0];
			`PL_REG_OFFSET:  offset_m = data;
			default:         return SLVERR; // Unmapped, ID or COUNT
		endcase
		return OKAY;
	endfunction

	function automatic axi_resp_e model_read(input logic [9:0] addr, output logic [31:0] data);
		data = 32'd0;
		case (addr)
			`PL_REG_ID:      data = `PL_ID_VALUE;
			`PL_REG_SCRATCH: data = scratch_m;
			`PL_REG_SOFTRST: data = {31'd0, softrst_m};
			`PL_REG_COUNT:   data = count_m;
			`PL_REG_MODE:    data = {31'd0, mode_m};
			`PL_REG_GAIN:    data = {16'd0, gain_m};
			`PL_REG_OFFSET:  data = offset_m;
			default:         return SLVERR;
		endcase
		return OKAY;
	endfunction

	// Integer product, floor division by 256, then clamp to the 16-bit range
	function automatic logic signed [15:0] iq_half(input logic signed [15:0] x);
		int p;
		p = (int'(x) * int'(gain_m)) >>> 8;
		if (p > 32767) return 16'sh7fff;
		if (p < -32768) return 16'sh8000;
		return p[15:0];
	endfunction

	function automatic logic [31:0] model_sample(input logic [31:0] w);
		sample_word_u in_w;
		sample_word_u out_w;
		in_w.raw = w;
		if (mode_m) begin
			out_w.iq.i = iq_half(in_w.iq.i);
			out_w.iq.q = iq_half(in_w.iq.q);
		end else begin
			out_w.raw = w + offset_m;
		end
		return out_w.raw;
	endfunction

	function automatic logic [9:0] unmapped_addr(input bit dsp_bank);
		int slot;
		slot = $urandom % 124;
		if (dsp_bank) return 10'h20C + 10'(slot * 4);
		return 10'h010 + 10'(slot * 4);
	endfunction

	// ------------------------------
	// Host accesses
	// ------------------------------
	task automatic reg_write(input logic [9:0] addr, input logic [31:0] data);
		axi_resp_e exp_resp;
		exp_resp = model_write(addr, data);
		next_cycle();
		awaddr  = addr;
		wdata   = data;
		awvalid = 1'b1;
		wvalid  = 1'b1;
		bready  = 1'b1;
		@(negedge cfgclk);
		while (!awready) @(negedge cfgclk);
		if (wready !== 1'b1) begin // Address and data are taken in the same cycle
			$display("ERROR wready at %h: got %h expected 1", addr, wready);
			errors++;
		end
		next_cycle();
		awvalid = 1'b0;
		wvalid  = 1'b0;
		@(negedge cfgclk);
		while (!bvalid) @(negedge cfgclk);
		if (bresp !== exp_resp) begin
			$display("ERROR bresp at %h: got %h expected %h", addr, bresp, exp_resp);
			errors++;
		end
		next_cycle();
		bready = 1'b0;
	endtask

	task automatic reg_read(input logic [9:0] addr);
		logic [31:0] exp_data;
		axi_resp_e   exp_resp;
		exp_resp = model_read(addr, exp_data);
		next_cycle();
		araddr  = addr;
		arvalid = 1'b1;
		rready  = 1'b1;
		@(negedge cfgclk);
		while (!arready) @(negedge cfgclk);
		next_cycle();
		arvalid = 1'b0;
		@(negedge cfgclk);
		while (!rvalid) @(negedge cfgclk);
		if (rresp !== exp_resp) begin
			$display("ERROR rresp at %h: got %h expected %h", addr, rresp, exp_resp);
			errors++;
		end
		if (rdata !== exp_data) begin
			$display("ERROR rdata at %h: got %h expected %h", addr, rdata, exp_data);
			errors++;
		end
		next_cycle();
		rready = 1'b0;
	endtask

	// ------------------------------
	// Stream traffic
	// ------------------------------
	task automatic run_stream(input int n, input int vpct, input int rpct);
		int sent;
		int got;
		bit taken;
		logic [31:0] exp_word;
		sent = 0;
		got = 0;
		taken = 1'b0;
		exp_q.delete();
		while (got < n) begin
			next_cycle();
			if (taken) s_tvalid = 1'b0;
			if (!s_tvalid && sent < n && ($urandom % 100) < vpct) begin
				s_tvalid = 1'b1; // Held with its data until accepted
				s_tdata  = $urandom;
			end
			m_tready = (($urandom % 100) < rpct);
			@(negedge cfgclk);
			taken = s_tvalid && s_tready;
			if (taken) begin
				exp_q.push_back(model_sample(s_tdata));
				sent++;
			end
			if (m_tvalid && m_tready) begin
				got++;
				count_m++;
				if (exp_q.size() == 0) begin
					$display("Output beat %0d arrived with no input beat pending", got);
					errors++;
				end else begin
					exp_word = exp_q.pop_front();
					if (m_tdata !== exp_word) begin
						$display("ERROR m_tdata beat %0d: got %h expected %h", got, m_tdata, exp_word);
						errors++;
					end
				end
			end
		end
		next_cycle();
		s_tvalid = 1'b0;
		m_tready = 1'b0;
	endtask

	// Two accepted beats with the output stalled leave both stages full
	task automatic fill_pipe();
		int k;
		k = 0;
		while (k < 2) begin
			next_cycle();
			s_tvalid = 1'b1;
			s_tdata  = $urandom;
			@(negedge cfgclk);
			if (s_tready) k++;
		end
		next_cycle();
		s_tvalid = 1'b0;
	endtask

	task automatic end_test(input string name, input int start_errors);
		tests_run++;
		if (errors == start_errors) begin
			$display("Test %0d %s: ok", tests_run, name);
		end else begin
			tests_failed++;
			$display("Test %0d %s: %0d errors", tests_run, name, errors - start_errors);
		end
	endtask

	task automatic check_flushed();
		@(negedge cfgclk);
		if (m_tvalid !== 1'b0) begin
			$display("ERROR m_tvalid: got %h expected 0", m_tvalid);
			errors++;
		end
	endtask

	initial begin
		void'($urandom(32'h91d5eb69));
		rst_n = 1'b0;
		{awvalid, wvalid, bready, arvalid, rready, s_tvalid, m_tready} = '0;
		awaddr = '0;
		araddr = '0;
		wdata = '0;
		s_tdata = '0;
		{scratch_m, offset_m, count_m, softrst_m, mode_m} = '0;
		gain_m = 16'sh0100; // Unity after reset
		repeat (5) @(posedge cfgclk);
		#1;
		rst_n = 1'b1;

		e0 = errors;
		reg_read(`PL_REG_ID);
		for (int k = 0; k < 8; k++) begin
			reg_write(`PL_REG_SCRATCH, $urandom);
			reg_read(`PL_REG_SCRATCH);
		end
		end_test("identity and scratch", e0);

		e0 = errors;
		for (int k = 0; k < 4; k++) begin
			reg_read(unmapped_addr(k[0]));
			reg_write(unmapped_addr(k[0]), $urandom);
		end
		reg_read(10'h006);
		reg_write(`PL_REG_ID, $urandom);
		reg_write(`PL_REG_COUNT, $urandom);
		reg_read(`PL_REG_ID);
		end_test("error responses", e0);

		e0 = errors;
		reg_write(`PL_REG_MODE, 32'd0);
		reg_write(`PL_REG_OFFSET, $urandom);
		reg_read(`PL_REG_OFFSET);
		run_stream(200, 100, 100);
		end_test("real mode offset", e0);

		e0 = errors;
		reg_write(`PL_REG_MODE, 32'd1);
		for (int k = 0; k < 5; k++) begin
			case (k)
				0: reg_write(`PL_REG_GAIN, 32'h0000_0100);
				1: reg_write(`PL_REG_GAIN, 32'h0401 + ($urandom % 32'h3BFF)); // Above 4.0
				2: reg_write(`PL_REG_GAIN, $urandom | 32'h8000); // Negative
				3: reg_write(`PL_REG_GAIN, 32'h0000_FF00);
				default: reg_write(`PL_REG_GAIN, $urandom);
			endcase
			reg_read(`PL_REG_GAIN);
			run_stream(40, 90, 90);
		end
		end_test("IQ gain and saturation", e0);

		e0 = errors;
		reg_write(`PL_REG_MODE, $urandom % 2);
		run_stream(300, 60, 50);
		reg_read(`PL_REG_COUNT);
		end_test("random back-pressure", e0);

		e0 = errors;
		fill_pipe();
		@(negedge cfgclk);
		if (m_tvalid !== 1'b1) begin
			$display("Pipeline did not hold a beat before the soft reset");
			errors++;
		end
		reg_write(`PL_REG_SOFTRST, 32'd1);
		check_flushed();
		next_cycle();
		s_tvalid = 1'b1; // A running pipeline would fill up while this is offered
		s_tdata  = $urandom;
		reg_read(`PL_REG_MODE);
		reg_read(`PL_REG_GAIN);
		reg_read(`PL_REG_OFFSET);
		reg_read(`PL_REG_SOFTRST);
		check_flushed();
		next_cycle();
		s_tvalid = 1'b0;
		reg_write(`PL_REG_SOFTRST, 32'd0);
		reg_write(`PL_REG_MODE, 32'd1);
		run_stream(50, 80, 80);
		reg_read(`PL_REG_COUNT);
		end_test("soft reset", e0);

		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// ==== flist.f ====
+incdir+include
source/pl_pkg.sv
source/axil_slave.sv
source/ctrl_regs.sv
source/dsp_regs.sv
source/sample_proc.sv
source/pl_top.sv
dv/pl_sva.sv
dv/pl_tb.sv

// ==== run.sh ====
#!/bin/sh
rm -f sim.log &&
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps --top-module pl_tb -f flist.f &&
./obj_dir/Vpl_tb > sim.log 2>&1 &&
grep -q "PASS: all tests" sim.log || exit 1
